/* hw/load_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module load_buffer (
    input  wire logic                        clock,
    input  wire logic                        reset,
    input  wire logic                        lb_alloc,
    input  wire logic                        load_resolve_valid,
    input  wire lsq_port_pkg::load_resolve_t load_resolve,
    input  wire lsq_cfg_pkg::sq_idx_t        sq_tail,
    input  wire lsq_cfg_pkg::sq_idx_t        sq_head,
    input  wire lsq_cfg_pkg::sq_idx_t        oldest_unresolved,
    input  wire logic                        all_resolved,
    output logic                             lb_full,
    output lsq_cfg_pkg::lb_idx_t             lb_alloc_idx,
    output logic                             issued_valid,
    output lsq_cfg_pkg::lb_entry_t           issued_load
);
    import lsq_cfg_pkg::*;

    lb_entry_t [LB_DEPTH-1:0] slots;
    logic [LB_DEPTH-1:0]      free_list;
    logic [LB_DEPTH-1:0]      issuable;
    lb_idx_t                  free_idx;
    lb_idx_t                  issue_idx;
    logic                     alloc_fire;
    logic                     issue_fire;
    sq_idx_t                  safe_dist;

    assign lb_full    = (free_list == '0);
    assign alloc_fire = lb_alloc && !lb_full;
    assign issue_fire = |issuable;

    // Distance from head to the oldest store whose address is unknown
    assign safe_dist = oldest_unresolved - sq_head;

    // Highest free slot wins
    always_comb begin
        free_idx = '0;
        for (int j = 0; j < LB_DEPTH; j++) begin
            if (free_list[j]) begin
                free_idx = lb_idx_t'(j);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Ordering check against older stores
    ////////////////////////////////////////////////////////////////////////////

    // Stores before the load's age are older; the one at the age is younger
    always_comb begin
        sq_idx_t age_dist;
        for (int j = 0; j < LB_DEPTH; j++) begin
            age_dist    = slots[j].age - sq_head;
            issuable[j] = !free_list[j] && slots[j].resolved &&
                          (all_resolved || age_dist <= safe_dist);
        end
    end

    // Lowest issuable slot wins
    always_comb begin
        issue_idx = '0;
        for (int j = LB_DEPTH - 1; j >= 0; j--) begin
            if (issuable[j]) begin
                issue_idx = lb_idx_t'(j);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Slot state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            free_list    <= '1;
            lb_alloc_idx <= '0;
            issued_valid <= 1'b0;
            for (int j = 0; j < LB_DEPTH; j++) begin
                slots[j].resolved <= 1'b0;
            end
        end else begin
            if (alloc_fire) begin
                lb_alloc_idx             <= free_idx;
                free_list[free_idx]      <= 1'b0;
                slots[free_idx].resolved <= 1'b0;
                slots[free_idx].age      <= sq_tail;
            end

            if (load_resolve_valid && !slots[load_resolve.lb_idx].resolved) begin
                slots[load_resolve.lb_idx].resolved <= 1'b1;
                slots[load_resolve.lb_idx].addr     <= load_resolve.base + load_resolve.offset;
                slots[load_resolve.lb_idx].prf_idx  <= load_resolve.prf_idx;
                slots[load_resolve.lb_idx].rob_idx  <= load_resolve.rob_idx;
            end

            // Issued slot goes back on the free list at once
            issued_valid <= issue_fire;
            if (issue_fire) begin
                free_list[issue_idx]      <= 1'b1;
                slots[issue_idx].resolved <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (issue_fire) begin
            issued_load <= slots[issue_idx];
        end
    end

endmodule

`default_nettype wire

/* hw/load_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module load_forward (
    input  wire logic                   issued_valid,
    input  wire lsq_cfg_pkg::lb_entry_t issued_load,
    input  wire lsq_cfg_pkg::sq_array_t sq_entries,
    input  wire lsq_cfg_pkg::sq_idx_t   sq_head,
    output lsq_port_pkg::load_result_t    load_result,
    output lsq_port_pkg::load_cache_req_t load_cache_req
);
    import lsq_cfg_pkg::*;

    sq_idx_t load_dist;
    logic    fwd_match;
    word_t   fwd_data;

    // Number of stores older than the load
    assign load_dist = issued_load.age - sq_head;

    ////////////////////////////////////////////////////////////////////////////
    // Address search, oldest first so the youngest match stays
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        sq_idx_t pos;
        fwd_match = 1'b0;
        fwd_data  = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            pos = sq_head + sq_idx_t'(i);
            if (sq_idx_t'(i) < load_dist && sq_entries[pos].resolved &&
                sq_entries[pos].addr == issued_load.addr) begin
                fwd_match = 1'b1;
                fwd_data  = sq_entries[pos].data;
            end
        end
    end

    // Forwarded loads skip the cache
    always_comb begin
        load_result.valid   = issued_valid && fwd_match;
        load_result.value   = fwd_data;
        load_result.prf_idx = issued_load.prf_idx;
        load_result.rob_idx = issued_load.rob_idx;

        load_cache_req.valid   = issued_valid && !fwd_match;
        load_cache_req.addr    = issued_load.addr;
        load_cache_req.prf_idx = issued_load.prf_idx;
        load_cache_req.rob_idx = issued_load.rob_idx;
    end

endmodule

`default_nettype wire

/* hw/load_store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module load_store_queue (
    input  wire logic                         clock,
    input  wire logic                         reset,
    input  wire logic                         lb_alloc,
    input  wire logic                         sq_alloc,
    input  wire logic                         load_resolve_valid,
    input  wire lsq_port_pkg::load_resolve_t  load_resolve,
    input  wire logic                         store_resolve_valid,
    input  wire lsq_port_pkg::store_resolve_t store_resolve,
    input  wire logic                         store_commit,
    output logic                              lb_full,
    output lsq_cfg_pkg::lb_idx_t              lb_alloc_idx,
    output logic                              sq_full,
    output lsq_cfg_pkg::sq_idx_t              sq_tail,
    output logic                              sq_head_resolved,
    output lsq_port_pkg::load_result_t        load_result,
    output lsq_port_pkg::load_cache_req_t     load_cache_req,
    output lsq_port_pkg::store_cache_req_t    store_cache_req
);
    import lsq_cfg_pkg::*;

    // Store queue view shared by the load side
    sq_array_t sq_entries;
    sq_idx_t   sq_head;
    sq_idx_t   oldest_unresolved;
    logic      all_resolved;

    // Issued load on its way to forwarding
    lb_entry_t issued_load;
    logic      issued_valid;

    store_queue store_queue_i (
        .clock               (clock),
        .reset               (reset),
        .sq_alloc            (sq_alloc),
        .store_resolve_valid (store_resolve_valid),
        .store_resolve       (store_resolve),
        .store_commit        (store_commit),
        .sq_full             (sq_full),
        .sq_tail             (sq_tail),
        .sq_head             (sq_head),
        .oldest_unresolved   (oldest_unresolved),
        .sq_head_resolved    (sq_head_resolved),
        .all_resolved        (all_resolved),
        .sq_entries          (sq_entries),
        .store_cache_req     (store_cache_req)
    );

    load_buffer load_buffer_i (
        .clock              (clock),
        .reset              (reset),
        .lb_alloc           (lb_alloc),
        .load_resolve_valid (load_resolve_valid),
        .load_resolve       (load_resolve),
        .sq_tail            (sq_tail),
        .sq_head            (sq_head),
        .oldest_unresolved  (oldest_unresolved),
        .all_resolved       (all_resolved),
        .lb_full            (lb_full),
        .lb_alloc_idx       (lb_alloc_idx),
        .issued_valid       (issued_valid),
        .issued_load        (issued_load)
    );

    load_forward load_forward_i (
        .issued_valid   (issued_valid),
        .issued_load    (issued_load),
        .sq_entries     (sq_entries),
        .sq_head        (sq_head),
        .load_result    (load_result),
        .load_cache_req (load_cache_req)
    );

endmodule

`default_nettype wire

/* hw/lsq_cfg_pkg.sv */
`default_nettype none

package lsq_cfg_pkg;

    // Queue sizes and tag widths
    localparam int XLEN      = 32;
    localparam int SQ_DEPTH  = 8;
    localparam int LB_DEPTH  = 4;
    localparam int ROB_IDX_W = 5;
    localparam int PRF_IDX_W = 6;
    localparam int SQ_IDX_W  = $clog2(SQ_DEPTH);
    localparam int LB_IDX_W  = $clog2(LB_DEPTH);

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [SQ_IDX_W-1:0]  sq_idx_t;
    typedef logic [SQ_IDX_W:0]    sq_cnt_t;
    typedef logic [LB_IDX_W-1:0]  lb_idx_t;
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;
    typedef logic [PRF_IDX_W-1:0] prf_idx_t;

    // One slot stays empty so tail never catches up with head
    localparam sq_cnt_t SQ_FULL_CNT = sq_cnt_t'(SQ_DEPTH - 1);

    typedef struct packed {
        logic     resolved;
        word_t    addr;
        word_t    data;
        rob_idx_t rob_idx;
    } sq_entry_t;

    // Age is the store queue tail seen at allocation
    typedef struct packed {
        logic     resolved;
        word_t    addr;
        sq_idx_t  age;
        prf_idx_t prf_idx;
        rob_idx_t rob_idx;
    } lb_entry_t;

    typedef sq_entry_t [SQ_DEPTH-1:0] sq_array_t;

endpackage

`default_nettype wire

/* hw/lsq_port_pkg.sv */
`default_nettype none

package lsq_port_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // From the reservation stations
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        lsq_cfg_pkg::sq_idx_t  sq_idx;
        lsq_cfg_pkg::word_t    base;
        lsq_cfg_pkg::word_t    offset;
        lsq_cfg_pkg::word_t    data;
        lsq_cfg_pkg::rob_idx_t rob_idx;
    } store_resolve_t;

    typedef struct packed {
        lsq_cfg_pkg::lb_idx_t  lb_idx;
        lsq_cfg_pkg::word_t    base;
        lsq_cfg_pkg::word_t    offset;
        lsq_cfg_pkg::prf_idx_t prf_idx;
        lsq_cfg_pkg::rob_idx_t rob_idx;
    } load_resolve_t;

    ////////////////////////////////////////////////////////////////////////////
    // To the result bus and the data cache
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                  valid;
        lsq_cfg_pkg::word_t    value;
        lsq_cfg_pkg::prf_idx_t prf_idx;
        lsq_cfg_pkg::rob_idx_t rob_idx;
    } load_result_t;

    typedef struct packed {
        logic                  valid;
        lsq_cfg_pkg::word_t    addr;
        lsq_cfg_pkg::prf_idx_t prf_idx;
        lsq_cfg_pkg::rob_idx_t rob_idx;
    } load_cache_req_t;

    typedef struct packed {
        logic                  valid;
        lsq_cfg_pkg::word_t    addr;
        lsq_cfg_pkg::word_t    data;
        lsq_cfg_pkg::rob_idx_t rob_idx;
    } store_cache_req_t;

endpackage

`default_nettype wire

/* hw/store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module store_queue (
    input  wire logic                         clock,
    input  wire logic                         reset,
    input  wire logic                         sq_alloc,
    input  wire logic                         store_resolve_valid,
    input  wire lsq_port_pkg::store_resolve_t store_resolve,
    input  wire logic                         store_commit,
    output logic                              sq_full,
    output lsq_cfg_pkg::sq_idx_t              sq_tail,
    output lsq_cfg_pkg::sq_idx_t              sq_head,
    output lsq_cfg_pkg::sq_idx_t              oldest_unresolved,
    output logic                              sq_head_resolved,
    output logic                              all_resolved,
    output lsq_cfg_pkg::sq_array_t            sq_entries,
    output lsq_port_pkg::store_cache_req_t    store_cache_req
);
    import lsq_cfg_pkg::*;

    sq_cnt_t sq_count;
    logic    alloc_fire;
    logic    commit_fire;
    logic    scan_found;
    sq_idx_t scan_idx;

    assign sq_full          = (sq_count == SQ_FULL_CNT);
    assign sq_head_resolved = sq_entries[sq_head].resolved;
    assign alloc_fire       = sq_alloc && !sq_full;

    // Head may only retire once its address and data are known
    assign commit_fire = store_commit && sq_head_resolved;

    ////////////////////////////////////////////////////////////////////////////
    // Head store to the data cache
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        store_cache_req.valid   = commit_fire;
        store_cache_req.addr    = sq_entries[sq_head].addr;
        store_cache_req.data    = sq_entries[sq_head].data;
        store_cache_req.rob_idx = sq_entries[sq_head].rob_idx;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Entry array and pointers
    ////////////////////////////////////////////////////////////////////////////

    // Depth is a power of two, so pointers wrap by plain increment
    always_ff @(posedge clock) begin
        if (reset) begin
            sq_head  <= '0;
            sq_tail  <= '0;
            sq_count <= '0;
            for (int i = 0; i < SQ_DEPTH; i++) begin
                sq_entries[i].resolved <= 1'b0;
            end
        end else begin
            if (alloc_fire) begin
                sq_entries[sq_tail].resolved <= 1'b0;
                sq_tail                      <= sq_tail + 1'b1;
            end

            // A second resolve of the same entry is dropped
            if (store_resolve_valid && !sq_entries[store_resolve.sq_idx].resolved) begin
                sq_entries[store_resolve.sq_idx].resolved <= 1'b1;
                sq_entries[store_resolve.sq_idx].addr     <= store_resolve.base +
                                                             store_resolve.offset;
                sq_entries[store_resolve.sq_idx].data     <= store_resolve.data;
                sq_entries[store_resolve.sq_idx].rob_idx  <= store_resolve.rob_idx;
            end

            if (commit_fire) begin
                sq_entries[sq_head].resolved <= 1'b0;
                sq_head                      <= sq_head + 1'b1;
            end

            case ({alloc_fire, commit_fire})
                2'b10:   sq_count <= sq_count + 1'b1;
                2'b01:   sq_count <= sq_count - 1'b1;
                default: sq_count <= sq_count;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Oldest unresolved store
    ////////////////////////////////////////////////////////////////////////////

    // Walk from youngest down to head, so the last hit is the oldest
    always_comb begin
        sq_idx_t pos;
        scan_found = 1'b0;
        scan_idx   = sq_head;
        for (int i = SQ_DEPTH - 1; i >= 0; i--) begin
            pos = sq_head + sq_idx_t'(i);
            if (sq_cnt_t'(i) < sq_count && !sq_entries[pos].resolved) begin
                scan_found = 1'b1;
                scan_idx   = pos;
            end
        end
    end

    // One cycle behind the array, which only makes the loads wait longer
    always_ff @(posedge clock) begin
        if (reset) begin
            oldest_unresolved <= '0;
            all_resolved      <= 1'b1;
        end else begin
            oldest_unresolved <= scan_idx;
            all_resolved      <= !scan_found;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the load/store queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_load_store_queue \
    -f vlog.f -Mdir obj_dir -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log \
    || echo "Build or simulation did not complete"

grep -q "Result: PASSED" sim.log 2>/dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* test/tb_load_store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_load_store_queue;
    import lsq_cfg_pkg::*;
    import lsq_port_pkg::*;

    localparam int LOAD_TIMEOUT = 20;
    localparam int QUIET_CYCLES = 6;

    typedef enum logic [2:0] {
        OP_IDLE, OP_ALLOC_ST, OP_ALLOC_LD, OP_RES_ST, OP_RES_LD, OP_COMMIT
    } op_t;

    typedef enum logic [2:0] {
        EV_NONE, EV_FULL, EV_NO_REQ, EV_ST_REQ, EV_NO_LOAD, EV_LD_CACHE, EV_LD_RESULT
    } ev_t;

    // One stimulus step and the event it should cause
    typedef struct packed {
        op_t        op;
        logic [2:0] idx;
        word_t      base;
        word_t      offset;
        word_t      data;
        prf_idx_t   prf;
        rob_idx_t   rob;
        ev_t        ev;
        word_t      exp_word;
        prf_idx_t   exp_prf;
        rob_idx_t   exp_rob;
    } row_t;

    logic             clock;
    logic             reset;
    logic             lb_alloc;
    logic             sq_alloc;
    logic             load_resolve_valid;
    load_resolve_t    load_resolve;
    logic             store_resolve_valid;
    store_resolve_t   store_resolve;
    logic             store_commit;
    logic             lb_full;
    lb_idx_t          lb_alloc_idx;
    logic             sq_full;
    sq_idx_t          sq_tail;
    logic             sq_head_resolved;
    load_result_t     load_result;
    load_cache_req_t  load_cache_req;
    store_cache_req_t store_cache_req;

    row_t rows[$];
    int   current_row;

    load_store_queue load_store_queue_i (
        .clock               (clock),
        .reset               (reset),
        .lb_alloc            (lb_alloc),
        .sq_alloc            (sq_alloc),
        .load_resolve_valid  (load_resolve_valid),
        .load_resolve        (load_resolve),
        .store_resolve_valid (store_resolve_valid),
        .store_resolve       (store_resolve),
        .store_commit        (store_commit),
        .lb_full             (lb_full),
        .lb_alloc_idx        (lb_alloc_idx),
        .sq_full             (sq_full),
        .sq_tail             (sq_tail),
        .sq_head_resolved    (sq_head_resolved),
        .load_result         (load_result),
        .load_cache_req      (load_cache_req),
        .store_cache_req     (store_cache_req)
    );

    always #20 clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // Checking and waiting
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string what, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: row %0d: %s is %h, expected %h",
                     $time, current_row, what, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "Stopped on the first mismatch");
        end
    endtask

    task automatic wait_for_load();
        int cycles;
        cycles = 0;
        while (!load_result.valid && !load_cache_req.valid) begin
            if (cycles == LOAD_TIMEOUT) begin
                $display("Timeout: no load left the queue within %0d cycles in row %0d",
                         LOAD_TIMEOUT, current_row);
                $display("Result: FAILED");
                $fatal(1, "Load wait timed out");
            end else begin
                @(negedge clock);
                cycles++;
            end
        end
    endtask

    // A load held back by an unresolved older store must stay quiet
    task automatic expect_no_load();
        repeat (QUIET_CYCLES) begin
            check_value("load_result.valid while blocked", load_result.valid, 0);
            check_value("load_cache_req.valid while blocked", load_cache_req.valid, 0);
            @(negedge clock);
        end
    endtask

    task automatic check_load_out(input row_t r);
        wait_for_load();
        if (r.ev == EV_LD_CACHE) begin
            check_value("load_result.valid", load_result.valid, 0);
            check_value("load_cache_req.addr", load_cache_req.addr, r.exp_word);
            check_value("load_cache_req.prf_idx", load_cache_req.prf_idx, r.exp_prf);
            check_value("load_cache_req.rob_idx", load_cache_req.rob_idx, r.exp_rob);
        end else begin
            check_value("load_cache_req.valid", load_cache_req.valid, 0);
            check_value("load_result.value", load_result.value, r.exp_word);
            check_value("load_result.prf_idx", load_result.prf_idx, r.exp_prf);
            check_value("load_result.rob_idx", load_result.rob_idx, r.exp_rob);
        end
    endtask

    task automatic check_reset_state();
        check_value("load_result.valid after reset", load_result.valid, 0);
        check_value("load_cache_req.valid after reset", load_cache_req.valid, 0);
        check_value("store_cache_req.valid after reset", store_cache_req.valid, 0);
        check_value("lb_full after reset", lb_full, 0);
        check_value("sq_full after reset", sq_full, 0);
        check_value("sq_tail after reset", sq_tail, 0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic add_row(input op_t op, input int idx, input word_t base, input word_t offset,
                           input word_t data, input int prf, input int rob, input ev_t ev,
                           input word_t exp_word, input int exp_prf, input int exp_rob);
        row_t r;
        r.op       = op;
        r.idx      = 3'(idx);
        r.base     = base;
        r.offset   = offset;
        r.data     = data;
        r.prf      = prf_idx_t'(prf);
        r.rob      = rob_idx_t'(rob);
        r.ev       = ev;
        r.exp_word = exp_word;
        r.exp_prf  = prf_idx_t'(exp_prf);
        r.exp_rob  = rob_idx_t'(exp_rob);
        rows.push_back(r);
    endtask

    // Columns: op, index, base, offset, data, prf, rob, event, expected word, prf, rob
    // For a commit the data column holds the expected store data
    task automatic build_table();
        // Free slots are taken from the top down
        add_row(OP_ALLOC_LD, 3, 0, 0, 0, 0, 0, EV_NONE, 0, 0, 0);
        add_row(OP_ALLOC_LD, 2, 0, 0, 0, 0, 0, EV_NONE, 0, 0, 0);
        add_row(OP_ALLOC_LD, 1, 0, 0, 0, 0, 0, EV_NONE, 0, 0, 0);
        add_row(OP_ALLOC_LD, 0, 0, 0, 0, 0, 0, EV_FULL, 0, 0, 0);
        // No stores yet, so each load goes to the cache
        add_row(OP_RES_LD, 3, 'h100, 'h8, 0, 1, 1, EV_LD_CACHE, 'h108, 1, 1);
        add_row(OP_RES_LD, 2, 'h200, 'h10, 0, 2, 2, EV_LD_CACHE, 'h210, 2, 2);
        add_row(OP_RES_LD, 1, 'h300, 'h4, 0, 3, 3, EV_LD_CACHE, 'h304, 3, 3);
        add_row(OP_RES_LD, 0, 'h400, 'hc, 0, 4, 4, EV_LD_CACHE, 'h40c, 4, 4);
        // Store queue keeps one entry empty
        for (int i = 0; i < SQ_DEPTH - 2; i++) begin
            add_row(OP_ALLOC_ST, i, 0, 0, 0, 0, 0, EV_NONE, 0, 0, 0);
        end
        add_row(OP_ALLOC_ST, 6, 0, 0, 0, 0, 0, EV_FULL, 0, 0, 0);
        // Commit needs a resolved head
        add_row(OP_COMMIT, 0, 0, 0, 0, 0, 0, EV_NO_REQ, 0, 0, 0);
        add_row(OP_RES_ST, 0, 'h1000, 'h20, 'haaaa_0000, 0, 5, EV_NONE, 0, 0, 0);
        add_row(OP_COMMIT, 0, 0, 0, 'haaaa_0000, 0, 0, EV_ST_REQ, 'h1020, 0, 5);
        // Load behind six unresolved stores, two of them at 0x3000
        add_row(OP_ALLOC_LD, 3, 0, 0, 0, 0, 0, EV_NONE, 0, 0, 0);
        add_row(OP_RES_LD, 3, 'h2000, 'h4, 0, 10, 20, EV_NO_LOAD, 0, 0, 0);
        add_row(OP_RES_ST, 1, 'h3100, 0, 'h1111_1111, 0, 6, EV_NONE, 0, 0, 0);
        add_row(OP_RES_ST, 2, 'h2ff0, 'h10, 'h2222_2222, 0, 7, EV_NONE, 0, 0, 0);
        add_row(OP_RES_ST, 3, 'h3200, 0, 'h3333_3333, 0, 8, EV_NONE, 0, 0, 0);
        add_row(OP_RES_ST, 4, 'h2f00, 'h100, 'h4444_4444, 0, 9, EV_NONE, 0, 0, 0);
        add_row(OP_RES_ST, 5, 'h3300, 0, 'h5555_5555, 0, 10, EV_NONE, 0, 0, 0);
        add_row(OP_RES_ST, 6, 'h3400, 0, 'h6666_6666, 0, 11, EV_LD_CACHE, 'h2004, 10, 20);
        // Youngest of the two matching stores wins
        add_row(OP_ALLOC_LD, 3, 0, 0, 0, 0, 0, EV_NONE, 0, 0, 0);
        add_row(OP_RES_LD, 3, 'h2800, 'h800, 0, 11, 21, EV_LD_RESULT, 'h4444_4444, 11, 21);
        // Younger store at the same address is not forwarded
        add_row(OP_ALLOC_LD, 3, 0, 0, 0, 0, 0, EV_NONE, 0, 0, 0);
        add_row(OP_ALLOC_ST, 7, 0, 0, 0, 0, 0, EV_FULL, 0, 0, 0);
        add_row(OP_RES_ST, 7, 'h5000, 0, 'h7777_7777, 0, 12, EV_NONE, 0, 0, 0);
        add_row(OP_RES_LD, 3, 'h4ff0, 'h10, 0, 12, 22, EV_LD_CACHE, 'h5000, 12, 22);
        // Drain two more stores in order
        add_row(OP_COMMIT, 0, 0, 0, 'h1111_1111, 0, 0, EV_ST_REQ, 'h3100, 0, 6);
        add_row(OP_COMMIT, 0, 0, 0, 'h2222_2222, 0, 0, EV_ST_REQ, 'h3000, 0, 7);
        add_row(OP_IDLE, 0, 0, 0, 0, 0, 0, EV_NONE, 0, 0, 0);
    endtask

    task automatic apply_row(input row_t r);
        @(posedge clock);
        case (r.op)
            OP_ALLOC_ST: sq_alloc <= 1'b1;
            OP_ALLOC_LD: lb_alloc <= 1'b1;
            OP_RES_ST: begin
                store_resolve_valid   <= 1'b1;
                store_resolve.sq_idx  <= sq_idx_t'(r.idx);
                store_resolve.base    <= r.base;
                store_resolve.offset  <= r.offset;
                store_resolve.data    <= r.data;
                store_resolve.rob_idx <= r.rob;
            end
            OP_RES_LD: begin
                load_resolve_valid   <= 1'b1;
                load_resolve.lb_idx  <= lb_idx_t'(r.idx);
                load_resolve.base    <= r.base;
                load_resolve.offset  <= r.offset;
                load_resolve.prf_idx <= r.prf;
                load_resolve.rob_idx <= r.rob;
            end
            OP_COMMIT: store_commit <= 1'b1;
            default: begin
            end
        endcase

        // Strobe is live in this cycle
        @(negedge clock);
        if (r.op == OP_ALLOC_ST) begin
            check_value("sq_tail at allocation", sq_tail, r.idx);
        end
        if (r.ev == EV_NO_REQ) begin
            check_value("sq_head_resolved", sq_head_resolved, 0);
            check_value("store_cache_req.valid", store_cache_req.valid, 0);
        end
        if (r.ev == EV_ST_REQ) begin
            check_value("sq_head_resolved", sq_head_resolved, 1);
            check_value("store_cache_req.valid", store_cache_req.valid, 1);
            check_value("store_cache_req.addr", store_cache_req.addr, r.exp_word);
            check_value("store_cache_req.data", store_cache_req.data, r.data);
            check_value("store_cache_req.rob_idx", store_cache_req.rob_idx, r.exp_rob);
        end

        @(posedge clock);
        sq_alloc            <= 1'b0;
        lb_alloc            <= 1'b0;
        store_resolve_valid <= 1'b0;
        load_resolve_valid  <= 1'b0;
        store_commit        <= 1'b0;

        @(negedge clock);
        if (r.op == OP_ALLOC_ST) begin
            check_value("sq_full", sq_full, r.ev == EV_FULL);
        end
        if (r.op == OP_ALLOC_LD) begin
            check_value("lb_alloc_idx", lb_alloc_idx, r.idx);
            check_value("lb_full", lb_full, r.ev == EV_FULL);
        end
        if (r.ev == EV_NO_LOAD) begin
            expect_no_load();
        end
        if (r.ev == EV_LD_CACHE || r.ev == EV_LD_RESULT) begin
            check_load_out(r);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clock               = 1'b0;
        reset               = 1'b1;
        lb_alloc            = 1'b0;
        sq_alloc            = 1'b0;
        load_resolve_valid  = 1'b0;
        load_resolve        = '0;
        store_resolve_valid = 1'b0;
        store_resolve       = '0;
        store_commit        = 1'b0;
        current_row         = -1;

        build_table();

        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_reset_state();

        foreach (rows[n]) begin
            current_row = n;
            apply_row(rows[n]);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/lsq_cfg_pkg.sv
hw/lsq_port_pkg.sv
hw/store_queue.sv
hw/load_buffer.sv
hw/load_forward.sv
hw/load_store_queue.sv
test/tb_load_store_queue.sv
